// ==== hw/bus_pkg.sv ====
package bus_pkg;

  localparam int addr_width        = 32;
  localparam int data_width        = 64;
  localparam int strb_width        = data_width / 8;
  localparam int byte_offset_width = $clog2(strb_width);
  localparam int num_targets       = 3;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;  // Any bit set makes a write

  // Index of each target on the decoder outputs
  typedef enum logic [1:0] {
    target_tim,
    target_clint,
    target_uart
  } target_e;

  // Old word with the strobed bytes replaced
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t merged;
    for (int b = 0; b < strb_width; b++) begin
      merged[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

// ==== hw/memory_map_pkg.sv ====
package memory_map_pkg;

  import bus_pkg::*;

  // Target windows, top address is exclusive
  localparam addr_t clint_base_addr = 32'h0200_0000;
  localparam addr_t clint_top_addr  = 32'h0200_c000;
  localparam addr_t uart_base_addr  = 32'h1000_0000;
  localparam addr_t uart_top_addr   = 32'h1000_1000;
  localparam addr_t tim_base_addr   = 32'h8000_0000;
  localparam addr_t tim_top_addr    = 32'h8000_0800;  // 256 words of 8 bytes

  // clint registers, offsets from clint_base_addr
  localparam addr_t clint_msip_offset     = 32'h0000_0000;
  localparam addr_t clint_mtimecmp_offset = 32'h0000_4000;
  localparam addr_t clint_mtime_offset    = 32'h0000_bff8;

endpackage

// ==== hw/bus_decoder.sv ====
module bus_decoder
  import bus_pkg::*;
  import memory_map_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   port_valid,
  input  logic                   port_instr,
  input  addr_t                  port_addr,
  input  data_t                  port_wdata,
  input  strb_t                  port_wstrb,
  output data_t                  port_rdata,
  output logic                   port_ready,
  output logic [num_targets-1:0] tgt_valid,
  output addr_t                  tgt_addr,
  output data_t                  tgt_wdata,
  output strb_t                  tgt_wstrb,
  output logic                   tgt_instr,
  input  data_t                  tgt_rdata [num_targets],
  input  logic [num_targets-1:0] tgt_ready
);

  addr_t base_addr;

  // Address decode, first matching window wins
  always_comb begin
    tgt_valid = '0;
    base_addr = '0;
    if (port_valid) begin
      if (port_addr >= tim_base_addr && port_addr < tim_top_addr) begin
        tgt_valid[target_tim] = 1'b1;
        base_addr = tim_base_addr;
      end else if (port_addr >= clint_base_addr && port_addr < clint_top_addr) begin
        tgt_valid[target_clint] = 1'b1;
        base_addr = clint_base_addr;
      end else if (port_addr >= uart_base_addr && port_addr < uart_top_addr) begin
        tgt_valid[target_uart] = 1'b1;
        base_addr = uart_base_addr;
      end
    end
  end

  assign tgt_addr  = port_addr - base_addr;  // Offset inside the window
  assign tgt_wdata = port_wdata;
  assign tgt_wstrb = port_wstrb;
  assign tgt_instr = port_instr;

  // Response from whichever target answers
  always_comb begin
    port_rdata = '0;
    port_ready = 1'b0;
    if (tgt_ready[target_tim]) begin
      port_rdata = tgt_rdata[target_tim];
      port_ready = 1'b1;
    end else if (tgt_ready[target_clint]) begin
      port_rdata = tgt_rdata[target_clint];
      port_ready = 1'b1;
    end else if (tgt_ready[target_uart]) begin
      port_rdata = tgt_rdata[target_uart];
      port_ready = 1'b1;
    end
  end

  // Unmapped addresses are never answered, so the master must not issue one
  assert property (@(posedge clock) disable iff (reset) port_valid |-> |tgt_valid);

  // One request in flight per port, so at most one arbiter answers it
  assert property (@(posedge clock) disable iff (reset) $onehot0(tgt_ready));

endmodule

// ==== hw/bus_arbiter.sv ====
module bus_arbiter
  import bus_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  i_valid,
  input  logic  i_instr,
  input  addr_t i_addr,
  input  data_t i_wdata,
  input  strb_t i_wstrb,
  output data_t i_rdata,
  output logic  i_ready,
  input  logic  d_valid,
  input  logic  d_instr,
  input  addr_t d_addr,
  input  data_t d_wdata,
  input  strb_t d_wstrb,
  output data_t d_rdata,
  output logic  d_ready,
  output logic  mem_valid,
  output logic  mem_instr,
  output addr_t mem_addr,
  output data_t mem_wdata,
  output strb_t mem_wstrb,
  input  data_t mem_rdata,
  input  logic  mem_ready
);

  localparam logic [1:0] idle    = 2'd0;
  localparam logic [1:0] serve_i = 2'd1;
  localparam logic [1:0] serve_d = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;
  logic       grant_i;
  logic       grant_d;

  // ##################################################
  // Grant FSM

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (d_valid) begin  // Data port wins a tie
          state_next = serve_d;
        end else if (i_valid) begin
          state_next = serve_i;
        end
      end
      serve_i, serve_d: begin
        if (mem_ready) begin
          state_next = idle;
        end
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // ##################################################
  // Request and response steering

  assign grant_i = (state == serve_i);
  assign grant_d = (state == serve_d);

  assign mem_valid = grant_i ? i_valid : grant_d & d_valid;
  assign mem_instr = grant_i ? i_instr : d_instr;
  assign mem_addr  = grant_i ? i_addr  : d_addr;
  assign mem_wdata = grant_i ? i_wdata : d_wdata;
  assign mem_wstrb = grant_i ? i_wstrb : d_wstrb;

  assign i_rdata = mem_rdata;
  assign d_rdata = mem_rdata;
  assign i_ready = grant_i & mem_ready;
  assign d_ready = grant_d & mem_ready;

  // Target answers only while a port holds the grant
  assert property (@(posedge clock) disable iff (reset) mem_ready |-> state != idle);

  // Ready only reaches a port that still holds its request
  assert property (@(posedge clock) disable iff (reset) i_ready |-> i_valid);
  assert property (@(posedge clock) disable iff (reset) d_ready |-> d_valid);

endmodule

// ==== hw/clint_timer.sv ====
module clint_timer
  import bus_pkg::*;
  import memory_map_pkg::*;
#(
  parameter int tick_div = 4
)
(
  input  logic  clock,
  input  logic  reset,
  input  logic  clint_valid,
  input  addr_t clint_addr,
  input  data_t clint_wdata,
  input  strb_t clint_wstrb,
  output data_t clint_rdata,
  output logic  clint_ready,
  output logic  msip,
  output logic  mtip,
  output data_t mtime
);

  localparam int prescale_width = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [prescale_width-1:0] prescale;
  logic                      tick;
  logic                      access;
  data_t                     mtimecmp;

  assign tick   = (prescale == prescale_width'(tick_div - 1));
  assign access = clint_valid && !clint_ready;  // Idle between pulses
  assign mtip   = (mtime >= mtimecmp);

  // mtime advances once per tick_div cycles
  always_ff @(posedge clock) begin
    if (reset) begin
      prescale <= '0;
      mtime    <= '0;
    end else if (tick) begin
      prescale <= '0;
      mtime    <= mtime + 1'b1;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      clint_ready <= 1'b0;
      msip        <= 1'b0;
      mtimecmp    <= '1;  // No timer interrupt until software sets it
    end else begin
      clint_ready <= access;
      if (access && clint_addr == clint_msip_offset && clint_wstrb[0]) begin
        msip <= clint_wdata[0];
      end
      if (access && clint_addr == clint_mtimecmp_offset) begin
        mtimecmp <= merge_bytes(mtimecmp, clint_wdata, clint_wstrb);
      end
    end
  end

  // Read data by offset
  always_ff @(posedge clock) begin
    if (access) begin
      case (clint_addr)
        clint_msip_offset:     clint_rdata <= data_t'(msip);
        clint_mtimecmp_offset: clint_rdata <= mtimecmp;
        clint_mtime_offset:    clint_rdata <= mtime;
        default:               clint_rdata <= '0;
      endcase
    end
  end

endmodule

// ==== hw/tim_memory.sv ====
module tim_memory
  import bus_pkg::*;
#(
  parameter int tim_words = 256
)
(
  input  logic  clock,
  input  logic  reset,
  input  logic  tim_valid,
  input  addr_t tim_addr,
  input  data_t tim_wdata,
  input  strb_t tim_wstrb,
  output data_t tim_rdata,
  output logic  tim_ready
);

  localparam int index_width = $clog2(tim_words);

  data_t                  mem [tim_words];
  logic [index_width-1:0] index;
  logic                   access;

  assign index  = tim_addr[index_width+byte_offset_width-1:byte_offset_width];
  assign access = tim_valid && !tim_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      tim_ready <= 1'b0;
    end else begin
      tim_ready <= access;  // One cycle pulse
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      if (|tim_wstrb) begin
        mem[index] <= merge_bytes(mem[index], tim_wdata, tim_wstrb);
      end
      tim_rdata <= mem[index];
    end
  end

  // Requester holds valid through the ready cycle, a new one only starts after it
  assert property (@(posedge clock) disable iff (reset) $rose(tim_valid) |-> !tim_ready);

endmodule

// ==== hw/soc_fabric.sv ====
module soc_fabric
  import bus_pkg::*;
#(
  parameter int tim_words = 256,
  parameter int tick_div  = 4
)
(
  input  logic  clock,
  input  logic  reset,
  input  logic  ibus_valid,
  input  logic  ibus_instr,
  input  addr_t ibus_addr,
  input  data_t ibus_wdata,
  input  strb_t ibus_wstrb,
  output data_t ibus_rdata,
  output logic  ibus_ready,
  input  logic  dbus_valid,
  input  logic  dbus_instr,
  input  addr_t dbus_addr,
  input  data_t dbus_wdata,
  input  strb_t dbus_wstrb,
  output data_t dbus_rdata,
  output logic  dbus_ready,
  output logic  uart_valid,
  output logic  uart_instr,
  output addr_t uart_addr,
  output data_t uart_wdata,
  output strb_t uart_wstrb,
  input  data_t uart_rdata,
  input  logic  uart_ready,
  output logic  msip,
  output logic  mtip,
  output data_t mtime
);

  // Decoder side
  logic [num_targets-1:0] ibus_tgt_valid;
  logic                   ibus_tgt_instr;
  addr_t                  ibus_tgt_addr;
  data_t                  ibus_tgt_wdata;
  strb_t                  ibus_tgt_wstrb;
  data_t                  ibus_tgt_rdata [num_targets];
  logic [num_targets-1:0] ibus_tgt_ready;

  logic [num_targets-1:0] dbus_tgt_valid;
  logic                   dbus_tgt_instr;
  addr_t                  dbus_tgt_addr;
  data_t                  dbus_tgt_wdata;
  strb_t                  dbus_tgt_wstrb;
  data_t                  dbus_tgt_rdata [num_targets];
  logic [num_targets-1:0] dbus_tgt_ready;

  // Target side, one element per arbiter
  logic [num_targets-1:0] mem_valid;
  logic [num_targets-1:0] mem_instr;
  addr_t                  mem_addr  [num_targets];
  data_t                  mem_wdata [num_targets];
  strb_t                  mem_wstrb [num_targets];
  data_t                  mem_rdata [num_targets];
  logic [num_targets-1:0] mem_ready;

  // ##################################################
  // Decoders

  bus_decoder ibus_decoder_comp (
    .clock      (clock),
    .reset      (reset),
    .port_valid (ibus_valid),
    .port_instr (ibus_instr),
    .port_addr  (ibus_addr),
    .port_wdata (ibus_wdata),
    .port_wstrb (ibus_wstrb),
    .port_rdata (ibus_rdata),
    .port_ready (ibus_ready),
    .tgt_valid  (ibus_tgt_valid),
    .tgt_addr   (ibus_tgt_addr),
    .tgt_wdata  (ibus_tgt_wdata),
    .tgt_wstrb  (ibus_tgt_wstrb),
    .tgt_instr  (ibus_tgt_instr),
    .tgt_rdata  (ibus_tgt_rdata),
    .tgt_ready  (ibus_tgt_ready)
  );

  bus_decoder dbus_decoder_comp (
    .clock      (clock),
    .reset      (reset),
    .port_valid (dbus_valid),
    .port_instr (dbus_instr),
    .port_addr  (dbus_addr),
    .port_wdata (dbus_wdata),
    .port_wstrb (dbus_wstrb),
    .port_rdata (dbus_rdata),
    .port_ready (dbus_ready),
    .tgt_valid  (dbus_tgt_valid),
    .tgt_addr   (dbus_tgt_addr),
    .tgt_wdata  (dbus_tgt_wdata),
    .tgt_wstrb  (dbus_tgt_wstrb),
    .tgt_instr  (dbus_tgt_instr),
    .tgt_rdata  (dbus_tgt_rdata),
    .tgt_ready  (dbus_tgt_ready)
  );

  // ##################################################
  // One arbiter per target

  for (genvar t = 0; t < num_targets; t++) begin : g_arbiter
    bus_arbiter arbiter_comp (
      .clock     (clock),
      .reset     (reset),
      .i_valid   (ibus_tgt_valid[t]),
      .i_instr   (ibus_tgt_instr),
      .i_addr    (ibus_tgt_addr),
      .i_wdata   (ibus_tgt_wdata),
      .i_wstrb   (ibus_tgt_wstrb),
      .i_rdata   (ibus_tgt_rdata[t]),
      .i_ready   (ibus_tgt_ready[t]),
      .d_valid   (dbus_tgt_valid[t]),
      .d_instr   (dbus_tgt_instr),
      .d_addr    (dbus_tgt_addr),
      .d_wdata   (dbus_tgt_wdata),
      .d_wstrb   (dbus_tgt_wstrb),
      .d_rdata   (dbus_tgt_rdata[t]),
      .d_ready   (dbus_tgt_ready[t]),
      .mem_valid (mem_valid[t]),
      .mem_instr (mem_instr[t]),
      .mem_addr  (mem_addr[t]),
      .mem_wdata (mem_wdata[t]),
      .mem_wstrb (mem_wstrb[t]),
      .mem_rdata (mem_rdata[t]),
      .mem_ready (mem_ready[t])
    );
  end

  // ##################################################
  // Targets

  tim_memory #(.tim_words (tim_words)) tim_comp (
    .clock     (clock),
    .reset     (reset),
    .tim_valid (mem_valid[target_tim]),
    .tim_addr  (mem_addr[target_tim]),
    .tim_wdata (mem_wdata[target_tim]),
    .tim_wstrb (mem_wstrb[target_tim]),
    .tim_rdata (mem_rdata[target_tim]),
    .tim_ready (mem_ready[target_tim])
  );

  clint_timer #(.tick_div (tick_div)) clint_comp (
    .clock       (clock),
    .reset       (reset),
    .clint_valid (mem_valid[target_clint]),
    .clint_addr  (mem_addr[target_clint]),
    .clint_wdata (mem_wdata[target_clint]),
    .clint_wstrb (mem_wstrb[target_clint]),
    .clint_rdata (mem_rdata[target_clint]),
    .clint_ready (mem_ready[target_clint]),
    .msip        (msip),
    .mtip        (mtip),
    .mtime       (mtime)
  );

  // uart is answered outside the fabric
  assign uart_valid              = mem_valid[target_uart];
  assign uart_instr              = mem_instr[target_uart];
  assign uart_addr               = mem_addr[target_uart];
  assign uart_wdata              = mem_wdata[target_uart];
  assign uart_wstrb              = mem_wstrb[target_uart];
  assign mem_rdata[target_uart]  = uart_rdata;
  assign mem_ready[target_uart]  = uart_ready;

endmodule

// ==== bench/soc_fabric_tasks.svh ====
// ##################################################
// Compare tasks

task automatic check_data(input string name, input data_t actual, input data_t expected);
  if (actual !== expected) begin
    abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                        $time, name, actual, expected));
  end
endtask

task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
  if (actual !== expected) begin
    abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                        $time, name, actual, expected));
  end
endtask

task automatic check_strb(input string name, input strb_t actual, input strb_t expected);
  if (actual !== expected) begin
    abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                        $time, name, actual, expected));
  end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    abort_run($sformatf("mismatch at time %0t: %s is %b, expected %b",
                        $time, name, actual, expected));
  end
endtask

// ##################################################
// Master port accesses

task automatic ibus_read(input addr_t addr, output data_t rdata, output int done_cycle);
  @(posedge clock);
  #1;
  ibus_valid = 1'b1;
  ibus_instr = 1'b1;
  ibus_addr  = addr;
  @(negedge clock);
  while (!ibus_ready) @(negedge clock);  // Request held until answered
  rdata      = ibus_rdata;
  done_cycle = cycle;
  @(posedge clock);
  #1;
  ibus_valid = 1'b0;
endtask

task automatic dbus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                           output data_t rdata, output int done_cycle);
  @(posedge clock);
  #1;
  dbus_valid = 1'b1;
  dbus_instr = 1'b0;
  dbus_addr  = addr;
  dbus_wdata = wdata;
  dbus_wstrb = wstrb;
  @(negedge clock);
  while (!dbus_ready) @(negedge clock);
  rdata      = dbus_rdata;
  done_cycle = cycle;
  @(posedge clock);
  #1;
  dbus_valid = 1'b0;
  dbus_wstrb = '0;
endtask

// ##################################################
// Directed tests

task automatic reset_values();
  @(negedge clock);
  check_bit("ibus_ready", ibus_ready, 1'b0);
  check_bit("dbus_ready", dbus_ready, 1'b0);
  check_bit("uart_valid", uart_valid, 1'b0);
  check_bit("msip", msip, 1'b0);
  check_bit("mtip", mtip, 1'b0);
  check_data("mtime", mtime, '0);
endtask

task automatic tim_byte_strobes();
  addr_t addr;
  data_t old_word;
  data_t new_word;
  data_t expected;
  data_t rdata;
  strb_t strb;
  int    done;
  for (int n = 0; n < 4; n++) begin
    addr     = tim_base_addr + addr_t'(($unsigned($random(seed)) % tim_words) * 8);
    old_word = {$random(seed), $random(seed)};
    new_word = {$random(seed), $random(seed)};
    strb     = strb_t'($random(seed));
    if (strb == '0 || strb == '1) begin
      strb = 8'h3c;  // Keep it partial
    end
    dbus_access(addr, old_word, '1, rdata, done);
    dbus_access(addr, new_word, strb, rdata, done);
    for (int b = 0; b < 8; b++) begin
      expected[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    ibus_read(addr, rdata, done);
    check_data("ibus_rdata", rdata, expected);
    dbus_access(addr, '0, '0, rdata, done);
    check_data("dbus_rdata", rdata, expected);
  end
endtask

task automatic uart_pass_through();
  addr_t offset;
  data_t wdata;
  data_t rdata;
  strb_t strb;
  int    done;
  for (int n = 0; n < 3; n++) begin
    offset = addr_t'($random(seed)) & 32'h0000_0ff8;
    wdata  = {$random(seed), $random(seed)};
    strb   = strb_t'($random(seed));
    dbus_access(uart_base_addr + offset, wdata, strb, rdata, done);
    check_addr("uart_addr", last_uart_addr, offset);
    check_bit("uart_instr", last_uart_instr, 1'b0);
    check_data("uart_wdata", last_uart_wdata, wdata);
    check_strb("uart_wstrb", last_uart_wstrb, strb);
    check_data("dbus_rdata", rdata, data_t'(~offset));
  end
  // Instruction fetch through the uart window
  offset = addr_t'($random(seed)) & 32'h0000_0ff8;
  ibus_read(uart_base_addr + offset, rdata, done);
  check_addr("uart_addr", last_uart_addr, offset);
  check_bit("uart_instr", last_uart_instr, 1'b1);
  check_strb("uart_wstrb", last_uart_wstrb, '0);
  check_data("ibus_rdata", rdata, data_t'(~offset));
endtask

task automatic tim_contention();
  addr_t addr_i;
  addr_t addr_d;
  data_t word_i;
  data_t word_d;
  data_t rdata_i;
  data_t rdata_d;
  int    done_i;
  int    done_d;
  addr_i = tim_base_addr + 32'h100;
  addr_d = tim_base_addr + 32'h208;
  word_i = {$random(seed), $random(seed)};
  word_d = {$random(seed), $random(seed)};
  dbus_access(addr_i, word_i, '1, rdata_i, done_i);
  dbus_access(addr_d, word_d, '1, rdata_d, done_d);
  fork  // Both ports raise valid in the same cycle
    ibus_read(addr_i, rdata_i, done_i);
    dbus_access(addr_d, '0, '0, rdata_d, done_d);
  join
  check_data("ibus_rdata", rdata_i, word_i);
  check_data("dbus_rdata", rdata_d, word_d);
  if (done_d > done_i) begin
    abort_run($sformatf("dbus_ready came %0d cycles after ibus_ready", done_d - done_i));
  end
endtask

task automatic clint_timer_irq();
  data_t rdata;
  data_t start;
  data_t target;
  data_t last_mtime;
  int    done;
  dbus_access(clint_base_addr + clint_msip_offset, 64'h1, 8'h01, rdata, done);
  check_bit("msip", msip, 1'b1);
  dbus_access(clint_base_addr + clint_mtime_offset, '0, '0, start, done);
  target = start + 8;
  dbus_access(clint_base_addr + clint_mtimecmp_offset, target, '1, rdata, done);
  dbus_access(clint_base_addr + clint_mtimecmp_offset, '0, '0, rdata, done);
  check_data("mtimecmp", rdata, target);
  check_bit("mtip", mtip, 1'b0);  // Compare value still ahead of mtime
  last_mtime = mtime;
  for (int n = 0; n < 16 * tick_div && !mtip; n++) begin
    @(negedge clock);
    if (mtime < last_mtime) begin
      abort_run($sformatf("mtime went backwards at time %0t", $time));
    end
    check_bit("mtip", mtip, mtime >= target);
    last_mtime = mtime;
  end
  check_bit("mtip", mtip, 1'b1);
endtask

// ==== bench/soc_fabric_tb.sv ====
module soc_fabric_tb
  import bus_pkg::*;
  import memory_map_pkg::*;
();

  localparam int period    = 8;
  localparam int num_tests = 5;
  localparam int timeout   = num_tests * 200 * period;
  localparam int tim_words = 256;
  localparam int tick_div  = 4;

  logic  clock, reset;
  logic  ibus_valid, ibus_instr, ibus_ready;
  addr_t ibus_addr;
  data_t ibus_wdata, ibus_rdata;
  strb_t ibus_wstrb;
  logic  dbus_valid, dbus_instr, dbus_ready;
  addr_t dbus_addr;
  data_t dbus_wdata, dbus_rdata;
  strb_t dbus_wstrb;
  logic  uart_valid, uart_instr, uart_ready;
  addr_t uart_addr;
  data_t uart_wdata, uart_rdata;
  strb_t uart_wstrb;
  logic  msip, mtip;
  data_t mtime;

  integer seed = 32'hf35;
  int     cycle = 0;
  addr_t  last_uart_addr;  // Offset seen by the uart responder
  logic   last_uart_instr;
  data_t  last_uart_wdata;
  strb_t  last_uart_wstrb;

  soc_fabric #(.tim_words (tim_words), .tick_div (tick_div)) DUT (.*);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  `include "soc_fabric_tasks.svh"

  initial begin : watchdog
    #(timeout);
    abort_run($sformatf("Watchdog expired at time %0t before the tests finished", $time));
  end

  // ##################################################
  // External uart device

  initial begin : uart_responder
    int delay;
    uart_ready = 1'b0;
    uart_rdata = '0;
    forever begin
      @(negedge clock);
      if (uart_valid) begin
        last_uart_addr  = uart_addr;
        last_uart_instr = uart_instr;
        last_uart_wdata = uart_wdata;
        last_uart_wstrb = uart_wstrb;
        delay = $unsigned($random(seed)) % 4;  // 0 to 3 wait cycles
        repeat (delay) @(posedge clock);
        @(posedge clock);
        #1;
        uart_rdata = data_t'(~uart_addr);
        uart_ready = 1'b1;
        @(posedge clock);
        #1;
        uart_ready = 1'b0;
      end
    end
  end

  // ##################################################
  // Test sequence

  initial begin
    reset      = 1'b1;
    ibus_valid = 1'b0;
    ibus_instr = 1'b0;
    ibus_addr  = '0;
    ibus_wdata = '0;
    ibus_wstrb = '0;
    dbus_valid = 1'b0;
    dbus_instr = 1'b0;
    dbus_addr  = '0;
    dbus_wdata = '0;
    dbus_wstrb = '0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    reset_values();
    tim_byte_strobes();
    uart_pass_through();
    tim_contention();
    clint_timer_irq();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== soc_fabric.f ====
+incdir+bench
hw/bus_pkg.sv
hw/memory_map_pkg.sv
hw/bus_decoder.sv
hw/bus_arbiter.sv
hw/clint_timer.sv
hw/tim_memory.sv
hw/soc_fabric.sv
bench/soc_fabric_tb.sv
